/* design/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data word width
`define CPU_XLEN 32

// instruction byte address
`define CPU_PC_W 10

// data byte address
`define CPU_DM_ADDR_W 12

// register index and count
`define CPU_REG_AW 5
`define CPU_REG_NUM 32

// first fetch after reset
`define CPU_RESET_PC 0

`endif

/* design/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

	// major opcodes, bits 30:25
	localparam logic [5:0] OP_ALU = 6'h20;
	localparam logic [5:0] OP_ADDI = 6'h28;
	localparam logic [5:0] OP_ORI = 6'h2c;
	localparam logic [5:0] OP_XORI = 6'h2b;
	localparam logic [5:0] OP_MOVI = 6'h22;
	localparam logic [5:0] OP_LWI = 6'h02;
	localparam logic [5:0] OP_SWI = 6'h0a;
	localparam logic [5:0] OP_BR = 6'h26;
	localparam logic [5:0] OP_J = 6'h24;

	// sub-ops of OP_ALU
	localparam logic [4:0] SUB_ADD = 5'h00;
	localparam logic [4:0] SUB_SUB = 5'h01;
	localparam logic [4:0] SUB_AND = 5'h02;
	localparam logic [4:0] SUB_XOR = 5'h03;
	localparam logic [4:0] SUB_OR = 5'h04;
	localparam logic [4:0] SUB_SLLI = 5'h08;
	localparam logic [4:0] SUB_SRLI = 5'h09;
	localparam logic [4:0] SUB_ROTRI = 5'h0b;

	typedef struct packed {
		logic zero;
		logic [5:0] opcode;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] ra;
		logic [`CPU_REG_AW-1:0] rb;
		logic [4:0] imm5;
		logic [4:0] sub_op;
	} reg_fmt_t;

	typedef struct packed {
		logic zero;
		logic [5:0] opcode;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] ra;
		logic [14:0] imm15;
	} imm_fmt_t;

	typedef struct packed {
		logic zero;
		logic [5:0] opcode;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] ra;
		logic ne;
		logic [13:0] imm14;
	} br_fmt_t;

	// bit 24 is unused by j
	typedef struct packed {
		logic zero;
		logic [5:0] opcode;
		logic rsvd;
		logic [23:0] imm24;
	} jmp_fmt_t;

	typedef union packed {
		reg_fmt_t reg_fmt;
		imm_fmt_t imm_fmt;
		br_fmt_t br_fmt;
		jmp_fmt_t jmp_fmt;
	} insn_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_ROR,
		ALU_PASSB
	} alu_op_e;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_sel_e;

	// SRC2_WOFF is the sign-extended imm15 scaled to a word offset
	typedef enum logic [2:0] {
		SRC2_RB,
		SRC2_SIMM15,
		SRC2_ZIMM15,
		SRC2_IMM5,
		SRC2_WOFF
	} src2_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		src2_sel_e src2_sel;
		wb_sel_e wb_sel;
		logic reg_write;
		logic dm_read;
		logic dm_write;
		logic branch;
		logic branch_ne;
		logic jump;
		logic [`CPU_REG_AW-1:0] rt_addr;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`CPU_XLEN-1:0] ra_data;
		logic [`CPU_XLEN-1:0] rt_data;
		logic [`CPU_XLEN-1:0] src2;
		logic [`CPU_PC_W-3:0] offset;
	} exec_t;

endpackage

/* design/cpu_controller.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_controller (
	input logic enable_memaccess,
	input logic rst,
	input cpu_pkg::insn_t insn,
	output logic phase_fetch,
	output logic phase_decode,
	output logic phase_execute,
	output logic phase_mem,
	output cpu_pkg::ctrl_t ctrl,
	output logic [`CPU_REG_AW-1:0] ra_addr,
	output logic [`CPU_REG_AW-1:0] rb_addr
);
	import cpu_pkg::*;

	logic [1:0] phase;

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	assign phase_fetch = (phase == 2'd0);
	assign phase_decode = (phase == 2'd1);
	assign phase_execute = (phase == 2'd2);
	assign phase_mem = (phase == 2'd3);

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.src2_sel = SRC2_RB;
		ctrl.wb_sel = WB_ALU;
		ctrl.rt_addr = insn.reg_fmt.rt;
		ra_addr = insn.reg_fmt.ra;
		rb_addr = insn.reg_fmt.rb;

		case (insn.reg_fmt.opcode)
			OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (insn.reg_fmt.sub_op)
					SUB_ADD: ctrl.alu_op = ALU_ADD;
					SUB_SUB: ctrl.alu_op = ALU_SUB;
					SUB_AND: ctrl.alu_op = ALU_AND;
					SUB_OR: ctrl.alu_op = ALU_OR;
					SUB_XOR: ctrl.alu_op = ALU_XOR;
					SUB_SRLI: begin
						ctrl.alu_op = ALU_SRL;
						ctrl.src2_sel = SRC2_IMM5;
					end
					SUB_SLLI: begin
						ctrl.alu_op = ALU_SLL;
						ctrl.src2_sel = SRC2_IMM5;
					end
					SUB_ROTRI: begin
						ctrl.alu_op = ALU_ROR;
						ctrl.src2_sel = SRC2_IMM5;
					end
					// unknown sub-op falls through as a no-op
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI, OP_ORI, OP_XORI, OP_MOVI: begin
				ra_addr = insn.imm_fmt.ra;
				ctrl.reg_write = 1'b1;
				case (insn.imm_fmt.opcode)
					OP_ADDI: ctrl.src2_sel = SRC2_SIMM15;
					OP_ORI: begin
						ctrl.alu_op = ALU_OR;
						ctrl.src2_sel = SRC2_ZIMM15;
					end
					OP_XORI: begin
						ctrl.alu_op = ALU_XOR;
						ctrl.src2_sel = SRC2_ZIMM15;
					end
					default: begin
						ctrl.alu_op = ALU_PASSB;
						ctrl.src2_sel = SRC2_SIMM15;
					end
				endcase
			end
			OP_LWI: begin
				ra_addr = insn.imm_fmt.ra;
				ctrl.src2_sel = SRC2_WOFF;
				ctrl.wb_sel = WB_MEM;
				ctrl.dm_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_SWI: begin
				ra_addr = insn.imm_fmt.ra;
				ctrl.src2_sel = SRC2_WOFF;
				ctrl.dm_write = 1'b1;
			end
			OP_BR: begin
				// compare ra with rt through the rb read port
				ra_addr = insn.br_fmt.ra;
				rb_addr = insn.br_fmt.rt;
				ctrl.alu_op = ALU_SUB;
				ctrl.branch = 1'b1;
				ctrl.branch_ne = insn.br_fmt.ne;
			end
			OP_J: ctrl.jump = 1'b1;
			default: ctrl.alu_op = ALU_ADD;
		endcase
	end

endmodule

/* design/cpu_regfile.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_regfile (
	input logic enable_memaccess,
	input logic rst,
	input logic read_en,
	input logic write_en,
	input logic [`CPU_REG_AW-1:0] ra_addr,
	input logic [`CPU_REG_AW-1:0] rb_addr,
	input logic [`CPU_REG_AW-1:0] rt_addr,
	input logic [`CPU_XLEN-1:0] wr_data,
	output logic [`CPU_XLEN-1:0] ra_data,
	output logic [`CPU_XLEN-1:0] rb_data,
	output logic [`CPU_XLEN-1:0] rt_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REG_NUM];
	logic [`CPU_XLEN-1:0] ra_q;
	logic [`CPU_XLEN-1:0] rb_q;
	logic [`CPU_XLEN-1:0] rt_q;

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_NUM; i++) begin
				regs[i] <= '0;
			end
			ra_q <= '0;
			rb_q <= '0;
			rt_q <= '0;
		end else begin
			if (write_en) begin
				regs[rt_addr] <= wr_data;
			end
			if (read_en) begin
				ra_q <= regs[ra_addr];
				rb_q <= regs[rb_addr];
				rt_q <= regs[rt_addr];
			end
		end
	end

	// live during the read phase, held afterwards
	assign ra_data = read_en ? regs[ra_addr] : ra_q;
	assign rb_data = read_en ? regs[rb_addr] : rb_q;
	assign rt_data = read_en ? regs[rt_addr] : rt_q;

endmodule

/* design/cpu_operand_mux.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_operand_mux (
	input cpu_pkg::src2_sel_e src2_sel,
	input cpu_pkg::wb_sel_e wb_sel,
	input logic [`CPU_XLEN-1:0] rb_data,
	input cpu_pkg::insn_t insn,
	input logic [`CPU_XLEN-1:0] alu_result,
	input logic [`CPU_XLEN-1:0] mem_data,
	output logic [`CPU_XLEN-1:0] src2,
	output logic [`CPU_XLEN-1:0] wr_data
);
	import cpu_pkg::*;

	logic [14:0] imm15;
	logic [`CPU_XLEN-1:0] simm15;

	assign imm15 = insn.imm_fmt.imm15;
	assign simm15 = {{(`CPU_XLEN-15){imm15[14]}}, imm15};

	always_comb begin
		case (src2_sel)
			SRC2_SIMM15: src2 = simm15;
			SRC2_ZIMM15: src2 = {{(`CPU_XLEN-15){1'b0}}, imm15};
			SRC2_IMM5: src2 = {{(`CPU_XLEN-5){1'b0}}, insn.reg_fmt.imm5};
			// word offset for lwi and swi
			SRC2_WOFF: src2 = {simm15[`CPU_XLEN-3:0], 2'b00};
			default: src2 = rb_data;
		endcase
	end

	assign wr_data = (wb_sel == WB_MEM) ? mem_data : alu_result;

endmodule

/* design/cpu_alu.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_alu (
	input cpu_pkg::alu_op_e op,
	input logic [`CPU_XLEN-1:0] src1,
	input logic [`CPU_XLEN-1:0] src2,
	output logic [`CPU_XLEN-1:0] result,
	output logic overflow,
	output logic zero
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic [2*`CPU_XLEN-1:0] rot_full;

	assign shamt = src2[4:0];
	assign sum = src1 + src2;
	assign diff = src1 - src2;
	assign rot_full = {src1, src1} >> shamt;

	always_comb begin
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum;
				overflow = (src1[`CPU_XLEN-1] == src2[`CPU_XLEN-1]) &&
					(sum[`CPU_XLEN-1] != src1[`CPU_XLEN-1]);
			end
			ALU_SUB: begin
				result = diff;
				overflow = (src1[`CPU_XLEN-1] != src2[`CPU_XLEN-1]) &&
					(diff[`CPU_XLEN-1] != src1[`CPU_XLEN-1]);
			end
			ALU_AND: result = src1 & src2;
			ALU_OR: result = src1 | src2;
			ALU_XOR: result = src1 ^ src2;
			ALU_SRL: result = src1 >> shamt;
			ALU_SLL: result = src1 << shamt;
			ALU_ROR: result = rot_full[`CPU_XLEN-1:0];
			default: result = src2;
		endcase
	end

	// zero after sub drives the branch compare
	assign zero = (result == '0);

endmodule

/* design/cpu_pc.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_pc (
	input logic enable_memaccess,
	input logic rst,
	input logic update,
	input logic branch,
	input logic branch_ne,
	input logic jump,
	input logic eq,
	input logic [`CPU_PC_W-3:0] offset,
	output logic [`CPU_PC_W-1:0] pc
);

	logic taken;
	logic [`CPU_PC_W-1:0] target;

	// relative target wraps within the instruction space
	assign target = pc + {offset, 2'b00};
	assign taken = jump | (branch & (eq != branch_ne));

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			pc <= `CPU_PC_W'(`CPU_RESET_PC);
		end else if (update) begin
			if (taken) begin
				pc <= target;
			end else begin
				pc <= pc + `CPU_PC_W'(4);
			end
		end
	end

endmodule

/* design/cpu_stage_regs.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_stage_regs (
	input logic enable_memaccess,
	input logic rst,
	input logic phase_fetch,
	input logic phase_decode,
	input logic phase_execute,
	input logic [`CPU_XLEN-1:0] instruction,
	input cpu_pkg::exec_t exec_in,
	input logic [`CPU_XLEN-1:0] alu_result,
	input logic alu_ovf,
	output cpu_pkg::insn_t insn,
	output cpu_pkg::exec_t exec_out,
	output logic [`CPU_XLEN-1:0] result_q,
	output logic overflow_q
);

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			insn <= '0;
			exec_out <= '0;
			result_q <= '0;
			overflow_q <= 1'b0;
		end else begin
			if (phase_fetch) begin
				insn <= instruction;
			end
			if (phase_decode) begin
				exec_out <= exec_in;
			end
			if (phase_execute) begin
				result_q <= alu_result;
				overflow_q <= alu_ovf;
			end
		end
	end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_top (
	input logic enable_memaccess,
	input logic rst,
	input logic [31:0] instruction,
	input logic [31:0] dm_out,
	output logic im_enable,
	output logic [`CPU_PC_W-1:0] im_address,
	output logic dm_read,
	output logic dm_write,
	output logic [`CPU_DM_ADDR_W-1:0] dm_address,
	output logic [31:0] dm_in,
	output logic alu_overflow
);
	import cpu_pkg::*;

	logic phase_fetch;
	logic phase_decode;
	logic phase_execute;
	logic phase_mem;
	ctrl_t ctrl;
	insn_t insn;
	exec_t exec_in;
	exec_t exec_out;
	logic [`CPU_REG_AW-1:0] ra_addr;
	logic [`CPU_REG_AW-1:0] rb_addr;
	logic [`CPU_XLEN-1:0] ra_data;
	logic [`CPU_XLEN-1:0] rb_data;
	logic [`CPU_XLEN-1:0] rt_data;
	logic [`CPU_XLEN-1:0] src2;
	logic [`CPU_XLEN-1:0] wr_data;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [`CPU_XLEN-1:0] result_q;
	logic alu_ovf;
	logic alu_zero;
	logic overflow_q;
	logic [`CPU_PC_W-1:0] pc;

	// decode bundle latched into the execute stage
	assign exec_in = '{
		ctrl: ctrl,
		ra_data: ra_data,
		rt_data: rt_data,
		src2: src2,
		offset: insn.jmp_fmt.imm24[`CPU_PC_W-3:0]
	};

	assign im_enable = phase_fetch;
	assign im_address = pc;
	assign dm_read = phase_mem & exec_out.ctrl.dm_read;
	assign dm_write = phase_mem & exec_out.ctrl.dm_write;
	assign dm_address = result_q[`CPU_DM_ADDR_W-1:0];
	assign dm_in = exec_out.rt_data;
	assign alu_overflow = overflow_q;

	cpu_controller u_controller (
		.enable_memaccess(enable_memaccess),
		.rst(rst),
		.insn(insn),
		.phase_fetch(phase_fetch),
		.phase_decode(phase_decode),
		.phase_execute(phase_execute),
		.phase_mem(phase_mem),
		.ctrl(ctrl),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr)
	);

	cpu_regfile u_regfile (
		.enable_memaccess(enable_memaccess),
		.rst(rst),
		.read_en(phase_decode),
		.write_en(phase_mem & exec_out.ctrl.reg_write),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(ctrl.rt_addr),
		.wr_data(wr_data),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	cpu_operand_mux u_operand_mux (
		.src2_sel(ctrl.src2_sel),
		.wb_sel(exec_out.ctrl.wb_sel),
		.rb_data(rb_data),
		.insn(insn),
		.alu_result(result_q),
		.mem_data(dm_out),
		.src2(src2),
		.wr_data(wr_data)
	);

	cpu_alu u_alu (
		.op(exec_out.ctrl.alu_op),
		.src1(exec_out.ra_data),
		.src2(exec_out.src2),
		.result(alu_result),
		.overflow(alu_ovf),
		.zero(alu_zero)
	);

	cpu_pc u_pc (
		.enable_memaccess(enable_memaccess),
		.rst(rst),
		.update(phase_execute),
		.branch(exec_out.ctrl.branch),
		.branch_ne(exec_out.ctrl.branch_ne),
		.jump(exec_out.ctrl.jump),
		.eq(alu_zero),
		.offset(exec_out.offset),
		.pc(pc)
	);

	cpu_stage_regs u_stage_regs (
		.enable_memaccess(enable_memaccess),
		.rst(rst),
		.phase_fetch(phase_fetch),
		.phase_decode(phase_decode),
		.phase_execute(phase_execute),
		.instruction(instruction),
		.exec_in(exec_in),
		.alu_result(alu_result),
		.alu_ovf(alu_ovf),
		.insn(insn),
		.exec_out(exec_out),
		.result_q(result_q),
		.overflow_q(overflow_q)
	);

endmodule

/* testbench/cpu_clock_gen.sv */
`timescale 1ns/100ps

module cpu_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// two rising edges with reset held, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* testbench/cpu_chk.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_chk (
	input logic enable_memaccess,
	input logic rst,
	input logic im_enable,
	input logic [`CPU_PC_W-1:0] im_address,
	input logic dm_read,
	input logic dm_write
);

	a_rd_wr_excl: assert property (@(posedge enable_memaccess) disable iff (rst)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high together");

	a_fetch_no_data: assert property (@(posedge enable_memaccess) disable iff (rst)
		im_enable |-> !(dm_read || dm_write))
		else $error("data strobe during instruction fetch");

	a_im_aligned: assert property (@(posedge enable_memaccess) disable iff (rst)
		im_address[1:0] == 2'b00)
		else $error("im_address not word aligned");

	// one fetch every four cycles
	a_fetch_period: assert property (@(posedge enable_memaccess) disable iff (rst)
		im_enable |=> !im_enable ##1 !im_enable ##1 !im_enable ##1 im_enable)
		else $error("im_enable period is not four cycles");

endmodule

bind cpu_top cpu_chk u_chk (
	.enable_memaccess(enable_memaccess),
	.rst(rst),
	.im_enable(im_enable),
	.im_address(im_address),
	.dm_read(dm_read),
	.dm_write(dm_write)
);

/* testbench/cpu_tb.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int HALT_TIMEOUT = 2000;

	logic enable_memaccess;
	logic rst;
	logic [31:0] instruction;
	logic [31:0] dm_out;
	logic im_enable;
	logic [`CPU_PC_W-1:0] im_address;
	logic dm_read;
	logic dm_write;
	logic [`CPU_DM_ADDR_W-1:0] dm_address;
	logic [31:0] dm_in;
	logic alu_overflow;

	logic [31:0] imem [256];
	logic [31:0] dmem [1024];

	// program under construction and the expected responses
	logic [31:0] prog [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_read [$];
	logic [31:0] mdl [32];

	// observed responses
	logic [31:0] store_addr_q [$];
	logic [31:0] store_data_q [$];
	logic [31:0] read_q [$];
	logic [31:0] fetch_q [$];
	logic ovf_q [$];
	int reads_before_store;

	int errors;
	int tests_run;
	int tests_failed;
	int cur_halt;
	int test_idx;

	cpu_clock_gen u_clock_gen (
		.clk(enable_memaccess),
		.rst(rst)
	);

	cpu_top u_dut (
		.enable_memaccess(enable_memaccess),
		.rst(rst),
		.instruction(instruction),
		.dm_out(dm_out),
		.im_enable(im_enable),
		.im_address(im_address),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_in(dm_in),
		.alu_overflow(alu_overflow)
	);

	assign instruction = im_enable ? imem[im_address[9:2]] : 32'h0;
	assign dm_out = dm_read ? dmem[dm_address[11:2]] : 32'h0;

	// sample mid-cycle where outputs are stable
	always @(negedge enable_memaccess) begin
		if (im_enable) begin
			fetch_q.push_back(32'(im_address));
			ovf_q.push_back(alu_overflow);
		end
		if (dm_read) begin
			read_q.push_back(32'(dm_address));
			if (store_addr_q.size() == 0) begin
				reads_before_store++;
			end
		end
		if (dm_write) begin
			store_addr_q.push_back(32'(dm_address));
			store_data_q.push_back(dm_in);
			dmem[dm_address[11:2]] = dm_in;
		end
	end

	function automatic logic [31:0] enc_reg(input logic [4:0] sub, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] imm5);
		return {1'b0, OP_ALU, rt, ra, rb, imm5, sub};
	endfunction

	function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [14:0] imm15);
		return {1'b0, op, rt, ra, imm15};
	endfunction

	function automatic logic [31:0] enc_br(input logic ne, input logic [4:0] rt,
		input logic [4:0] ra, input logic [13:0] imm14);
		return {1'b0, OP_BR, rt, ra, ne, imm14};
	endfunction

	function automatic logic [31:0] enc_j(input logic [23:0] imm24);
		return {1'b0, OP_J, 1'b0, imm24};
	endfunction

	// register operations as the instruction set defines them
	function automatic logic [31:0] model_reg_op(input logic [4:0] sub, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] imm5);
		int sh;
		sh = 32 - int'(imm5);
		case (sub)
			SUB_ADD: return a + b;
			SUB_SUB: return a - b;
			SUB_AND: return a & b;
			SUB_OR: return a | b;
			SUB_XOR: return a ^ b;
			SUB_SRLI: return a >> imm5;
			SUB_SLLI: return a << imm5;
			SUB_ROTRI: return (a >> imm5) | (a << sh);
			default: return 32'h0;
		endcase
	endfunction

	task automatic emit_op(input logic [4:0] sub, input logic [4:0] rt, input logic [4:0] ra,
		input logic [4:0] rb, input logic [4:0] imm5);
		prog.push_back(enc_reg(sub, rt, ra, rb, imm5));
		mdl[rt] = model_reg_op(sub, mdl[ra], mdl[rb], imm5);
	endtask

	task automatic emit_imm(input logic [5:0] op, input logic [4:0] rt, input logic [4:0] ra,
		input logic [14:0] imm15);
		logic [31:0] sext;
		logic [31:0] zext;
		sext = {{17{imm15[14]}}, imm15};
		zext = {17'h0, imm15};
		prog.push_back(enc_imm(op, rt, ra, imm15));
		case (op)
			OP_ADDI: mdl[rt] = mdl[ra] + sext;
			OP_ORI: mdl[rt] = mdl[ra] | zext;
			OP_XORI: mdl[rt] = mdl[ra] ^ zext;
			default: mdl[rt] = sext;
		endcase
	endtask

	// store rt to word address word_idx with r0 as base
	task automatic emit_store(input logic [4:0] rt, input int word_idx);
		prog.push_back(enc_imm(OP_SWI, rt, 5'd0, 15'(word_idx)));
		exp_addr.push_back(32'(word_idx * 4));
		exp_data.push_back(mdl[rt]);
	endtask

	task automatic emit_load(input logic [4:0] rt, input logic [4:0] ra, input int word_off);
		logic [31:0] addr;
		addr = mdl[ra] + 32'(word_off * 4);
		prog.push_back(enc_imm(OP_LWI, rt, ra, 15'(word_off)));
		exp_read.push_back(addr);
		mdl[rt] = dmem[addr[11:2]];
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic start_test();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_read.delete();
	endtask

	// loads prog at base, redirects the spinning halt to it and waits for the new halt
	task automatic run_program(input string name, output int base);
		int halt;
		int n;
		bit seen;
		base = (test_idx % 2) * 128;
		test_idx++;
		halt = base + prog.size();
		@(negedge enable_memaccess);
		store_addr_q.delete();
		store_data_q.delete();
		read_q.delete();
		fetch_q.delete();
		ovf_q.delete();
		for (int i = 0; i < prog.size(); i++) begin
			imem[base + i] = prog[i];
		end
		imem[halt] = enc_j(24'h0);
		if (cur_halt >= 0) begin
			imem[cur_halt] = enc_j(24'(base - cur_halt));
		end
		cur_halt = halt;
		seen = 1'b0;
		n = 0;
		while (!seen && n < HALT_TIMEOUT) begin
			@(negedge enable_memaccess);
			if (fetch_q.size() > 0 && fetch_q[fetch_q.size() - 1] == 32'(halt * 4)) begin
				seen = 1'b1;
			end
			n++;
		end
		assert (seen)
		else begin
			$display("timeout in test %s: halt address %0h was never fetched", name, halt * 4);
			errors++;
		end
	endtask

	task automatic check_stores(input string name);
		assert (store_addr_q.size() == exp_addr.size())
		else begin
			$display("test %s saw %0d stores where %0d were expected", name,
				store_addr_q.size(), exp_addr.size());
			errors++;
		end
		for (int i = 0; i < exp_addr.size() && i < store_addr_q.size(); i++) begin
			check_val($sformatf("%s dm_address[%0d]", name, i), store_addr_q[i], exp_addr[i]);
			check_val($sformatf("%s dm_in[%0d]", name, i), store_data_q[i], exp_data[i]);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	function automatic int find_fetch(input int addr);
		for (int i = 0; i < fetch_q.size(); i++) begin
			if (fetch_q[i] == 32'(addr)) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic test_reset();
		int e0;
		int base;
		e0 = errors;
		start_test();
		emit_imm(OP_MOVI, 5'd1, 5'd0, 15'h0123);
		emit_store(5'd1, 4);
		run_program("reset", base);
		assert (fetch_q.size() > 0)
		else begin
			$display("test reset saw no fetch at all");
			errors++;
		end
		if (fetch_q.size() > 0) begin
			check_val("first im_address", fetch_q[0], 32'(`CPU_RESET_PC));
		end
		check_val("dm_read before first store", 32'(reads_before_store), 32'h0);
		check_stores("reset");
		end_test("reset", e0);
	endtask

	task automatic test_alu_ops();
		int e0;
		int base;
		e0 = errors;
		start_test();
		emit_imm(OP_MOVI, 5'd1, 5'd0, 15'h1234);
		emit_imm(OP_MOVI, 5'd2, 5'd0, 15'h7ffb);
		emit_op(SUB_ADD, 5'd3, 5'd1, 5'd2, 5'd0);
		emit_store(5'd3, 20);
		emit_op(SUB_SUB, 5'd3, 5'd1, 5'd2, 5'd0);
		emit_store(5'd3, 21);
		emit_op(SUB_AND, 5'd3, 5'd1, 5'd2, 5'd0);
		emit_store(5'd3, 22);
		emit_op(SUB_OR, 5'd3, 5'd1, 5'd2, 5'd0);
		emit_store(5'd3, 23);
		emit_op(SUB_XOR, 5'd3, 5'd1, 5'd2, 5'd0);
		emit_store(5'd3, 24);
		emit_op(SUB_SRLI, 5'd3, 5'd2, 5'd0, 5'd3);
		emit_store(5'd3, 25);
		emit_op(SUB_SLLI, 5'd3, 5'd1, 5'd0, 5'd9);
		emit_store(5'd3, 26);
		emit_op(SUB_ROTRI, 5'd3, 5'd1, 5'd0, 5'd7);
		emit_store(5'd3, 27);
		emit_imm(OP_ADDI, 5'd3, 5'd1, 15'h7f9c);
		emit_store(5'd3, 28);
		emit_imm(OP_ORI, 5'd3, 5'd2, 15'h7abc);
		emit_store(5'd3, 29);
		emit_imm(OP_XORI, 5'd3, 5'd1, 15'h5555);
		emit_store(5'd3, 30);
		run_program("alu_ops", base);
		check_stores("alu_ops");
		end_test("alu_ops", e0);
	endtask

	task automatic test_load_store();
		int e0;
		int base;
		e0 = errors;
		start_test();
		dmem[100] = $urandom;
		emit_imm(OP_MOVI, 5'd4, 5'd0, 15'd8);
		emit_load(5'd6, 5'd4, 98);
		emit_imm(OP_ADDI, 5'd7, 5'd6, 15'd77);
		emit_store(5'd7, 101);
		run_program("load_store", base);
		assert (read_q.size() == 1)
		else begin
			$display("test load_store saw %0d loads where 1 was expected", read_q.size());
			errors++;
		end
		if (read_q.size() > 0) begin
			check_val("load dm_address", read_q[0], exp_read[0]);
		end
		check_stores("load_store");
		end_test("load_store", e0);
	endtask

	task automatic test_branches();
		int e0;
		int base;
		int s;
		int exp_off [8];
		e0 = errors;
		start_test();
		exp_off = '{0, 1, 2, 4, 5, 6, 8, 10};
		emit_imm(OP_MOVI, 5'd1, 5'd0, 15'd7);
		emit_imm(OP_MOVI, 5'd2, 5'd0, 15'd7);
		// beq taken, bne not taken, beq not taken, bne taken, then j
		prog.push_back(enc_br(1'b0, 5'd2, 5'd1, 14'd2));
		emit_imm(OP_MOVI, 5'd3, 5'd0, 15'd1);
		prog.push_back(enc_br(1'b1, 5'd2, 5'd1, 14'd2));
		prog.push_back(enc_br(1'b0, 5'd0, 5'd1, 14'd2));
		prog.push_back(enc_br(1'b1, 5'd0, 5'd1, 14'd2));
		emit_imm(OP_MOVI, 5'd3, 5'd0, 15'd2);
		prog.push_back(enc_j(24'd2));
		emit_imm(OP_MOVI, 5'd3, 5'd0, 15'd3);
		run_program("branches", base);
		s = find_fetch(base * 4);
		assert (s >= 0 && s + $size(exp_off) <= fetch_q.size())
		else begin
			$display("test branches could not find the fetch sequence of the program");
			errors++;
		end
		if (s >= 0 && s + $size(exp_off) <= fetch_q.size()) begin
			for (int i = 0; i < $size(exp_off); i++) begin
				check_val($sformatf("im_address[%0d]", i), fetch_q[s + i],
					32'((base + exp_off[i]) * 4));
			end
		end
		end_test("branches", e0);
	endtask

	task automatic test_overflow();
		int e0;
		int base;
		int s;
		e0 = errors;
		start_test();
		emit_imm(OP_MOVI, 5'd1, 5'd0, 15'h7fff);
		emit_op(SUB_SRLI, 5'd1, 5'd1, 5'd0, 5'd1);
		emit_op(SUB_ADD, 5'd2, 5'd1, 5'd1, 5'd0);
		emit_op(SUB_SUB, 5'd3, 5'd1, 5'd1, 5'd0);
		run_program("overflow", base);
		s = find_fetch(base * 4);
		assert (s >= 0 && s + 5 <= ovf_q.size())
		else begin
			$display("test overflow could not find the fetch sequence of the program");
			errors++;
		end
		if (s >= 0 && s + 5 <= ovf_q.size()) begin
			// value seen at the following fetch belongs to the previous instruction
			check_val("alu_overflow after add", 32'(ovf_q[s + 3]), 32'h1);
			check_val("alu_overflow after sub", 32'(ovf_q[s + 4]), 32'h0);
		end
		end_test("overflow", e0);
	endtask

	task automatic test_random_ops();
		int e0;
		int base;
		logic [31:0] r;
		logic [4:0] subs [8];
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		e0 = errors;
		start_test();
		subs = '{SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR, SUB_SRLI, SUB_SLLI, SUB_ROTRI};
		for (int k = 1; k <= 9; k++) begin
			dmem[150 + k] = $urandom;
			emit_load(5'(k), 5'd0, 150 + k);
		end
		for (int i = 0; i < 12; i++) begin
			r = $urandom;
			rt = 5'(5 + r % 5);
			r = $urandom;
			ra = 5'(1 + r % 9);
			r = $urandom;
			rb = 5'(1 + r % 9);
			r = $urandom;
			emit_op(subs[r % 8], rt, ra, rb, r[12:8]);
			emit_store(rt, 200 + i);
		end
		run_program("random_ops", base);
		check_stores("random_ops");
		end_test("random_ops", e0);
	endtask

	initial begin
		int n;
		void'($urandom(80));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_halt = -1;
		test_idx = 0;
		reads_before_store = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = enc_j(24'h0);
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
		end
		for (int i = 0; i < 32; i++) begin
			mdl[i] = 32'h0;
		end

		n = 0;
		while (rst !== 1'b0 && n < 20) begin
			@(negedge enable_memaccess);
			n++;
		end
		assert (rst === 1'b0)
		else begin
			$display("reset was never released");
			errors++;
		end
		test_reset();
		test_alu_ops();
		test_load_store();
		test_branches();
		test_overflow();
		test_random_ops();

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* cpu.f */
+incdir+design
design/cpu_pkg.sv
design/cpu_controller.sv
design/cpu_regfile.sv
design/cpu_operand_mux.sv
design/cpu_alu.sv
design/cpu_pc.sv
design/cpu_stage_regs.sv
design/cpu_top.sv
testbench/cpu_clock_gen.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --assert --top-module cpu_tb -f cpu.f \
	&& ./obj_dir/Vcpu_tb | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
